//--- vlog.f
common/cpu_pkg.sv
common/issue_if.sv
fetch/insn_memory.sv
fetch/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/alu_stage.sv
design/cpu_core.sv
testbench/cpu_core_tb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module cpu_core_tb -f vlog.f -o cpu_core_tb_sim \
	&& ./obj_dir/cpu_core_tb_sim > sim.log 2>&1 \
	|| { echo "Build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
grep -q "Test OK" sim.log && echo "Simulation passed" \
	|| { cat sim.log; echo "Simulation failed"; exit 1; }

//--- testbench/cpu_core_tb.sv
`default_nettype none

module cpu_core_tb;
	import cpu_pkg::*;

	localparam int CLOCK_PERIOD = 10;
	localparam int RESET_CYCLES = 4;
	localparam int IDLE_CYCLES = 6;
	localparam int DRAIN_CYCLES = 20;
	localparam int N_ENTRIES = 34;
	localparam int TIMEOUT_CYCLES =
		N_ENTRIES * 20 + N_ENTRIES + RESET_CYCLES + IDLE_CYCLES + DRAIN_CYCLES;

	logic clock;
	logic rst;
	logic load_en;
	imem_addr_t load_addr;
	word_t load_data;
	logic run;
	logic stall;
	logic result_valid;
	imem_addr_t result_pc;
	reg_addr_t result_dest;
	word_t result_data;

	// Program and expected results, indexed by pc
	string table_name [N_ENTRIES];
	word_t table_insn [N_ENTRIES];
	reg_addr_t table_dest [N_ENTRIES];
	word_t table_data [N_ENTRIES];
	int retire_q [$];

	int n_entries = 0;
	int errors = 0;
	int got = 0;
	integer seed;

	cpu_core DUT (
		.clock        (clock),
		.rst          (rst),
		.load_en      (load_en),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.run          (run),
		.stall        (stall),
		.result_valid (result_valid),
		.result_pc    (result_pc),
		.result_dest  (result_dest),
		.result_data  (result_data)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	function automatic word_t r_type_word(funct_t funct, int rd, int rs, int rt, int shamt);
		return {OP_RTYPE, reg_addr_t'(rs), reg_addr_t'(rt), reg_addr_t'(rd),
			shamt_t'(shamt), funct};
	endfunction

	function automatic word_t imm_word(opcode_t op, int rs, int rt, logic [15:0] imm);
		return {op, reg_addr_t'(rs), reg_addr_t'(rt), imm};
	endfunction

	function automatic word_t mul_word(int rd, int rs, int rt);
		return {OP_MUL, reg_addr_t'(rs), reg_addr_t'(rt), reg_addr_t'(rd), 5'd0, FN_MUL};
	endfunction

	task automatic add_entry(string name, word_t insn, bit retires, int dest, word_t data);
		table_name[n_entries] = name;
		table_insn[n_entries] = insn;
		table_dest[n_entries] = reg_addr_t'(dest);
		table_data[n_entries] = data;
		if (retires) begin
			retire_q.push_back(n_entries);
		end
		n_entries++;
	endtask

	task automatic build_table();
		add_entry("lui_r1", imm_word(OP_LUI, 0, 1, 16'h8000), 1'b1, 1, 32'h8000_0000);
		add_entry("ori_r1", imm_word(OP_ORI, 1, 1, 16'h00f0), 1'b1, 1, 32'h8000_00f0);
		add_entry("addi_neg", imm_word(OP_ADDI, 0, 2, 16'hfffb), 1'b1, 2, 32'hffff_fffb);
		add_entry("addiu_r3", imm_word(OP_ADDIU, 0, 3, 16'h0007), 1'b1, 3, 32'h0000_0007);
		add_entry("add", r_type_word(FN_ADD, 4, 2, 3, 0), 1'b1, 4, 32'h0000_0002);
		add_entry("sub", r_type_word(FN_SUB, 5, 3, 2, 0), 1'b1, 5, 32'h0000_000c);
		add_entry("addu", r_type_word(FN_ADDU, 6, 1, 3, 0), 1'b1, 6, 32'h8000_00f7);
		add_entry("subu", r_type_word(FN_SUBU, 7, 0, 3, 0), 1'b1, 7, 32'hffff_fff9);
		add_entry("and", r_type_word(FN_AND, 8, 1, 2, 0), 1'b1, 8, 32'h8000_00f0);
		add_entry("or", r_type_word(FN_OR, 9, 3, 5, 0), 1'b1, 9, 32'h0000_000f);
		add_entry("xor_dep", r_type_word(FN_XOR, 10, 9, 3, 0), 1'b1, 10, 32'h0000_0008);
		add_entry("nor", r_type_word(FN_NOR, 11, 3, 0, 0), 1'b1, 11, 32'hffff_fff8);
		add_entry("slt_neg", r_type_word(FN_SLT, 12, 2, 3, 0), 1'b1, 12, 32'h0000_0001);
		add_entry("sltu_neg", r_type_word(FN_SLTU, 13, 2, 3, 0), 1'b1, 13, 32'h0000_0000);
		add_entry("nop", 32'h0000_0000, 1'b0, 0, 32'h0);
		add_entry("sll", r_type_word(FN_SLL, 14, 0, 3, 4), 1'b1, 14, 32'h0000_0070);
		add_entry("srl", r_type_word(FN_SRL, 15, 0, 1, 4), 1'b1, 15, 32'h0800_000f);
		add_entry("sra", r_type_word(FN_SRA, 16, 0, 1, 4), 1'b1, 16, 32'hf800_000f);
		add_entry("sllv", r_type_word(FN_SLLV, 17, 14, 3, 0), 1'b1, 17, 32'h0007_0000);
		add_entry("srlv", r_type_word(FN_SRLV, 18, 3, 2, 0), 1'b1, 18, 32'h01ff_ffff);
		add_entry("srav", r_type_word(FN_SRAV, 19, 3, 2, 0), 1'b1, 19, 32'hffff_ffff);
		add_entry("mul_neg", mul_word(20, 2, 3), 1'b1, 20, 32'hffff_ffdd);
		add_entry("mul_dep", mul_word(21, 20, 20), 1'b1, 21, 32'h0000_04c9);
		add_entry("slti_neg", imm_word(OP_SLTI, 3, 22, 16'hfffc), 1'b1, 22, 32'h0000_0000);
		add_entry("sltiu_max", imm_word(OP_SLTIU, 3, 23, 16'hffff), 1'b1, 23, 32'h0000_0001);
		add_entry("xori_zext", imm_word(OP_XORI, 2, 24, 16'hffff), 1'b1, 24, 32'hffff_0004);
		add_entry("ori_zext", imm_word(OP_ORI, 0, 25, 16'h8001), 1'b1, 25, 32'h0000_8001);
		add_entry("addi_r0", imm_word(OP_ADDI, 3, 0, 16'h0005), 1'b1, 0, 32'h0000_000c);
		add_entry("read_r0", r_type_word(FN_ADDU, 26, 0, 3, 0), 1'b1, 26, 32'h0000_0007);
		add_entry("bad_opcode", 32'hfc22_1234, 1'b0, 0, 32'h0);
		add_entry("addiu_r27", imm_word(OP_ADDIU, 26, 27, 16'h0001), 1'b1, 27, 32'h0000_0008);
		add_entry("slt_zero", r_type_word(FN_SLT, 28, 1, 0, 0), 1'b1, 28, 32'h0000_0001);
		add_entry("bad_mul_funct", 32'h7022_f000, 1'b0, 0, 32'h0); // SPECIAL2, funct 0
		add_entry("subu_last", r_type_word(FN_SUBU, 30, 21, 26, 0), 1'b1, 30, 32'h0000_04c2);
	endtask

	task automatic finish_run();
		$display("Checks done: %0d errors, %0d of %0d results seen",
			errors, got, retire_q.size());
		if (errors == 0 && got == retire_q.size()) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	endtask

	initial begin : stimulus
		seed = 32'h19d80f3c;
		rst = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		run = 1'b0;
		stall = 1'b0;
		build_table();
		repeat (RESET_CYCLES) @(posedge clock);
		rst <= 1'b0;
		for (int i = 0; i < n_entries; i++) begin
			@(posedge clock);
			load_en <= 1'b1;
			load_addr <= imem_addr_t'(i);
			load_data <= table_insn[i];
		end
		@(posedge clock);
		load_en <= 1'b0;
		repeat (IDLE_CYCLES) begin
			@(negedge clock);
			assert (!result_valid) else begin
				$display("Result reported before run was raised");
				errors++;
			end
		end
		@(posedge clock);
		run <= 1'b1;
		forever begin
			@(posedge clock);
			stall <= (($random(seed) & 3) == 0); // About one cycle in four
		end
	end

	initial begin : check_results
		int idx;
		wait (run);
		while (got < retire_q.size()) begin
			@(negedge clock);
			if (result_valid && !stall) begin
				idx = retire_q[got];
				assert (result_pc == imem_addr_t'(idx)) else begin
					$display("ERROR %s pc: expected %0d, actual %0d",
						table_name[idx], idx, result_pc);
					errors++;
				end
				assert (result_dest == table_dest[idx]) else begin
					$display("ERROR %s dest: expected %0d, actual %0d",
						table_name[idx], table_dest[idx], result_dest);
					errors++;
				end
				assert (result_data == table_data[idx]) else begin
					$display("ERROR %s data: expected %h, actual %h",
						table_name[idx], table_data[idx], result_data);
					errors++;
				end
				got++;
			end
		end
		// Anything after the last entry is one result too many
		repeat (DRAIN_CYCLES) begin
			@(negedge clock);
			assert (!(result_valid && !stall)) else begin
				$display("More results than expected, extra one at pc %0d", result_pc);
				errors++;
			end
		end
		finish_run();
	end

	initial begin : watchdog
		#(TIMEOUT_CYCLES * CLOCK_PERIOD);
		$display("Timed out with results missing, only %0d of %0d arrived",
			got, retire_q.size());
		errors++;
		finish_run();
	end

endmodule

`default_nettype wire

//--- design/cpu_core.sv
`default_nettype none

module cpu_core (
	input  logic clock,
	input  logic rst,
	input  logic load_en,
	input  cpu_pkg::imem_addr_t load_addr,
	input  cpu_pkg::word_t load_data,
	input  logic run,
	input  logic stall,
	output logic result_valid,
	output cpu_pkg::imem_addr_t result_pc,
	output cpu_pkg::reg_addr_t result_dest,
	output cpu_pkg::word_t result_data
);
	import cpu_pkg::*;

	logic fetch_valid;
	imem_addr_t fetch_pc;
	word_t fetch_insn;
	logic wb_en;
	reg_addr_t wb_addr;
	word_t wb_data;

	issue_if issue ();

	fetch_stage u_fetch (
		.clock       (clock),
		.rst         (rst),
		.run         (run),
		.stall       (stall),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.fetch_insn  (fetch_insn)
	);

	decode_stage u_decode (
		.clock       (clock),
		.rst         (rst),
		.stall       (stall),
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.fetch_insn  (fetch_insn),
		.wb_en       (wb_en),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.issue       (issue.producer)
	);

	alu_stage u_alu (
		.clock        (clock),
		.rst          (rst),
		.stall        (stall),
		.issue        (issue.consumer),
		.wb_en        (wb_en),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.result_valid (result_valid),
		.result_pc    (result_pc),
		.result_dest  (result_dest),
		.result_data  (result_data)
	);

endmodule

`default_nettype wire

//--- execute/alu_stage.sv
`default_nettype none

module alu_stage (
	input  logic clock,
	input  logic rst,
	input  logic stall,
	issue_if.consumer issue,
	output logic wb_en,
	output cpu_pkg::reg_addr_t wb_addr,
	output cpu_pkg::word_t wb_data,
	output logic result_valid,
	output cpu_pkg::imem_addr_t result_pc,
	output cpu_pkg::reg_addr_t result_dest,
	output cpu_pkg::word_t result_data
);
	import cpu_pkg::*;

	word_t a, b;
	word_t alu_out;
	shamt_t sh;

	assign a = issue.operand_a;
	assign b = issue.operand_b;
	assign sh = b[4:0];

	always_comb begin
		case (issue.op)
			ALU_ADD: alu_out = a + b;
			ALU_SUB: alu_out = a - b;
			ALU_AND: alu_out = a & b;
			ALU_OR: alu_out = a | b;
			ALU_XOR: alu_out = a ^ b;
			ALU_NOR: alu_out = ~(a | b);
			ALU_SLT: alu_out = word_t'($signed(a) < $signed(b));
			ALU_SLTU: alu_out = word_t'(a < b);
			ALU_SLL: alu_out = a << sh;
			ALU_SRL: alu_out = a >> sh;
			ALU_SRA: alu_out = word_t'($signed(a) >>> sh);
			ALU_MUL: alu_out = a * b; // Low 32 bits
			ALU_LUI: alu_out = {b[15:0], 16'h0000};
			default: alu_out = '0;
		endcase
	end

	// Write lands on the edge that retires the instruction
	assign wb_en = issue.valid && issue.writes && !stall;
	assign wb_addr = issue.dest;
	assign wb_data = alu_out;

	always_ff @(posedge clock) begin
		if (rst) begin
			result_valid <= 1'b0;
		end else if (!stall) begin
			result_valid <= issue.valid && issue.writes;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			result_pc <= issue.pc;
			result_dest <= issue.dest;
			result_data <= alu_out;
		end
	end

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
`default_nettype none

module decode_stage (
	input  logic clock,
	input  logic rst,
	input  logic stall,
	input  logic fetch_valid,
	input  cpu_pkg::imem_addr_t fetch_pc,
	input  cpu_pkg::word_t fetch_insn,
	input  logic wb_en,
	input  cpu_pkg::reg_addr_t wb_addr,
	input  cpu_pkg::word_t wb_data,
	issue_if.producer issue
);
	import cpu_pkg::*;

	opcode_t opcode;
	reg_addr_t rs, rt, rd;
	shamt_t shamt;
	funct_t funct;
	logic [15:0] imm;
	word_t rs_val, rt_val, imm_sext, imm_zext;
	alu_op_e op;
	word_t operand_a, operand_b;
	reg_addr_t dest;
	logic known;

	assign opcode = fetch_insn[31:26];
	assign rs = fetch_insn[25:21];
	assign rt = fetch_insn[20:16];
	assign rd = fetch_insn[15:11];
	assign shamt = fetch_insn[10:6];
	assign funct = fetch_insn[5:0];
	assign imm = fetch_insn[15:0];
	assign imm_sext = {{16{imm[15]}}, imm};
	assign imm_zext = {16'h0000, imm};

	reg_file u_reg_file (
		.clock   (clock),
		.rst     (rst),
		.rs_addr (rs),
		.rt_addr (rt),
		.rs_data (rs_val),
		.rt_data (rt_val),
		.wb_en   (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

	always_comb begin
		op = ALU_ADD;
		operand_a = rs_val;
		operand_b = rt_val;
		dest = rd;
		known = 1'b1;
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FN_ADD, FN_ADDU: op = ALU_ADD; // No overflow trap
					FN_SUB, FN_SUBU: op = ALU_SUB;
					FN_AND: op = ALU_AND;
					FN_OR: op = ALU_OR;
					FN_XOR: op = ALU_XOR;
					FN_NOR: op = ALU_NOR;
					FN_SLT: op = ALU_SLT;
					FN_SLTU: op = ALU_SLTU;
					FN_SLL, FN_SLLV: op = ALU_SLL;
					FN_SRL, FN_SRLV: op = ALU_SRL;
					FN_SRA, FN_SRAV: op = ALU_SRA;
					default: known = 1'b0;
				endcase
				if (op inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
					operand_a = rt_val;
					// funct bit 2 marks the variable forms
					operand_b = funct[2] ? rs_val : word_t'(shamt);
				end
			end
			OP_MUL: begin
				op = ALU_MUL;
				known = (funct == FN_MUL);
			end
			OP_ADDI, OP_ADDIU: begin
				op = ALU_ADD;
				operand_b = imm_sext;
				dest = rt;
			end
			OP_SLTI, OP_SLTIU: begin
				op = (opcode == OP_SLTI) ? ALU_SLT : ALU_SLTU;
				operand_b = imm_sext; // Sign-extended for both
				dest = rt;
			end
			OP_ORI, OP_XORI: begin
				op = (opcode == OP_ORI) ? ALU_OR : ALU_XOR;
				operand_b = imm_zext;
				dest = rt;
			end
			OP_LUI: begin
				op = ALU_LUI;
				operand_a = '0;
				operand_b = imm_zext;
				dest = rt;
			end
			default: known = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			issue.valid <= 1'b0;
			issue.writes <= 1'b0;
		end else if (!stall) begin
			issue.valid <= fetch_valid;
			issue.writes <= known && (fetch_insn != '0);
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			issue.pc <= fetch_pc;
			issue.op <= op;
			issue.operand_a <= operand_a;
			issue.operand_b <= operand_b;
			issue.dest <= dest;
		end
	end

endmodule

`default_nettype wire

//--- decode/reg_file.sv
`default_nettype none

module reg_file (
	input  logic clock,
	input  logic rst,
	input  cpu_pkg::reg_addr_t rs_addr,
	input  cpu_pkg::reg_addr_t rt_addr,
	output cpu_pkg::word_t rs_data,
	output cpu_pkg::word_t rt_data,
	input  logic wb_en,
	input  cpu_pkg::reg_addr_t wb_addr,
	input  cpu_pkg::word_t wb_data
);
	import cpu_pkg::*;

	word_t regs [32];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && wb_addr != '0) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// Write-through so the next instruction sees the value being retired
	assign rs_data = (rs_addr == '0) ? '0 :
		(wb_en && wb_addr == rs_addr) ? wb_data : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 :
		(wb_en && wb_addr == rt_addr) ? wb_data : regs[rt_addr];

endmodule

`default_nettype wire

//--- fetch/fetch_stage.sv
`default_nettype none

module fetch_stage (
	input  logic clock,
	input  logic rst,
	input  logic run,
	input  logic stall,
	input  logic load_en,
	input  cpu_pkg::imem_addr_t load_addr,
	input  cpu_pkg::word_t load_data,
	output logic fetch_valid,
	output cpu_pkg::imem_addr_t fetch_pc,
	output cpu_pkg::word_t fetch_insn
);
	import cpu_pkg::*;

	imem_addr_t pc;
	logic read_en;

	assign read_en = run && !stall;

	insn_memory u_insn_memory (
		.clock     (clock),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.read_en   (read_en),
		.read_addr (pc),
		.read_data (fetch_insn)
	);

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= '0;
			fetch_valid <= 1'b0;
		end else if (!stall) begin
			fetch_valid <= run; // Lines up with the memory read register
			if (run) begin
				pc <= pc + 1'b1; // Wraps at the top of memory
				fetch_pc <= pc;
			end
		end
	end

endmodule

`default_nettype wire

//--- fetch/insn_memory.sv
`default_nettype none

module insn_memory (
	input  logic clock,
	input  logic load_en,
	input  cpu_pkg::imem_addr_t load_addr,
	input  cpu_pkg::word_t load_data,
	input  logic read_en,
	input  cpu_pkg::imem_addr_t read_addr,
	output cpu_pkg::word_t read_data
);
	import cpu_pkg::*;

	word_t mem [IMEM_WORDS];

	// Unloaded words decode as NOP
	initial begin
		for (int i = 0; i < IMEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clock) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end
		if (read_en) begin // Held while stalled
			read_data <= mem[read_addr];
		end
	end

endmodule

`default_nettype wire

//--- common/issue_if.sv
`default_nettype none

// One decoded instruction on its way from decode to execute
interface issue_if;
	import cpu_pkg::*;

	logic valid;
	imem_addr_t pc;
	alu_op_e op;
	word_t operand_a;
	word_t operand_b;
	reg_addr_t dest;
	logic writes; // Writes a register and retires

	modport producer (
		output valid, pc, op, operand_a, operand_b, dest, writes
	);

	modport consumer (
		input valid, pc, op, operand_a, operand_b, dest, writes
	);

endinterface

`default_nettype wire

//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int IMEM_ADDR_BITS = 8;
	localparam int IMEM_WORDS = 1 << IMEM_ADDR_BITS;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [IMEM_ADDR_BITS-1:0] imem_addr_t; // Word index, also the pc
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [4:0] shamt_t;

	// Primary opcodes
	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_MUL = 6'b011100; // SPECIAL2
	localparam opcode_t OP_ADDI = 6'b001000;
	localparam opcode_t OP_ADDIU = 6'b001001;
	localparam opcode_t OP_SLTI = 6'b001010;
	localparam opcode_t OP_SLTIU = 6'b001011;
	localparam opcode_t OP_ORI = 6'b001101;
	localparam opcode_t OP_XORI = 6'b001110;
	localparam opcode_t OP_LUI = 6'b001111;

	// R-type function codes
	localparam funct_t FN_ADD = 6'b100000;
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUB = 6'b100010;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND = 6'b100100;
	localparam funct_t FN_OR = 6'b100101;
	localparam funct_t FN_XOR = 6'b100110;
	localparam funct_t FN_NOR = 6'b100111;
	localparam funct_t FN_SLT = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;
	localparam funct_t FN_SLL = 6'b000000;
	localparam funct_t FN_SRL = 6'b000010;
	localparam funct_t FN_SRA = 6'b000011;
	localparam funct_t FN_SLLV = 6'b000100;
	localparam funct_t FN_SRLV = 6'b000110;
	localparam funct_t FN_SRAV = 6'b000111;
	localparam funct_t FN_MUL = 6'b000010; // Under OP_MUL only

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_MUL,
		ALU_LUI
	} alu_op_e;

endpackage

`default_nettype wire
